// File: files.f
+incdir+source
source/rv_core_pkg.sv
source/rv_control.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_retire.sv
source/rv_core.sv
testbench/rv_core_properties.sv
testbench/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# build the rv_core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module rv_core_tb \
    -f files.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/rv_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulator exited with an error"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// File: source/rv_control.sv
// rv_control turns the major opcode into the datapath control levels
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_control (
    input  rv_core_pkg::opcode_t opcode,
    output logic                 branch,
    output logic                 mem_read,
    output logic                 mem_to_reg,
    output logic                 mem_write,
    output logic                 alu_src,
    output logic                 reg_write_en,
    output rv_core_pkg::alu_op_t alu_op
);

    always_comb begin
        // unknown opcodes fall through as a nop that writes nothing
        branch       = 1'b0;
        mem_read     = 1'b0;
        mem_to_reg   = 1'b0;
        mem_write    = 1'b0;
        alu_src      = 1'b0;
        reg_write_en = 1'b0;
        alu_op       = 2'd0;

        case (opcode)
            `RV_OP_R: begin
                alu_op       = 2'd2;
                reg_write_en = 1'b1;
            end
            `RV_OP_IMM: begin
                // funct3 still picks the operation, only operand b differs
                alu_op       = 2'd2;
                alu_src      = 1'b1;
                reg_write_en = 1'b1;
            end
            `RV_OP_LOAD: begin
                mem_read     = 1'b1;
                mem_to_reg   = 1'b1;
                alu_src      = 1'b1;
                reg_write_en = 1'b1;
            end
            `RV_OP_STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
            end
            `RV_OP_BRANCH: begin
                // subtract rs1 - rs2, zero test happens in execute
                branch = 1'b1;
                alu_op = 2'd1;
            end
            default: begin
                branch = 1'b0;
            end
        endcase
    end

endmodule

// File: source/rv_core.sv
// rv_core single-cycle rv32i subset top level connecting decode, execute and retire
`timescale 1ns/1ps

module rv_core (
    input  logic               clk,
    input  logic               arst_n,
    input  rv_core_pkg::word_t instr,
    input  rv_core_pkg::word_t mem_rdata,
    output rv_core_pkg::word_t pc,
    output rv_core_pkg::word_t mem_addr,
    output rv_core_pkg::word_t mem_wdata,
    output logic               mem_read,
    output logic               mem_write
);

    import rv_core_pkg::*;

    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic [2:0] funct3;
    logic       funct7_bit5;
    word_t      imm;
    logic       branch;
    logic       mem_to_reg;
    logic       alu_src;
    logic       reg_write;
    alu_op_t    alu_op;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      alu_result;
    logic       branch_taken;
    word_t      rd_data;

    rv_decode u_decode (
        .instr        (instr),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .funct3       (funct3),
        .funct7_bit5  (funct7_bit5),
        .imm          (imm),
        .branch       (branch),
        .mem_read     (mem_read),
        .mem_to_reg   (mem_to_reg),
        .mem_write    (mem_write),
        .alu_src      (alu_src),
        .reg_write_en (reg_write),
        .alu_op       (alu_op)
    );

    rv_regfile u_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .reg_write (reg_write),
        .rd_data   (rd_data),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    rv_execute u_execute (
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .alu_op       (alu_op),
        .funct3       (funct3),
        .funct7_bit5  (funct7_bit5),
        .alu_src      (alu_src),
        .branch       (branch),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    rv_retire u_retire (
        .clk          (clk),
        .arst_n       (arst_n),
        .imm          (imm),
        .branch_taken (branch_taken),
        .mem_to_reg   (mem_to_reg),
        .alu_result   (alu_result),
        .mem_rdata    (mem_rdata),
        .pc           (pc),
        .rd_data      (rd_data)
    );

    // data port: address from the ALU, store data straight from rs2
    assign mem_addr  = alu_result;
    assign mem_wdata = rs2_data;

endmodule

// File: source/rv_core_params.svh
// rv32i subset core constants: widths, reset pc and major opcodes
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// major opcodes handled by the core
`define RV_OP_R      7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011

`endif

// File: source/rv_core_pkg.sv
// rv32i subset core shared vector types for the datapath and testbench
`include "rv_core_params.svh"

package rv_core_pkg;

    // one data word, address or instruction
    typedef logic [`RV_XLEN-1:0] word_t;

    // major opcode field, instr[6:0]
    typedef logic [6:0] opcode_t;

    // register index
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

    // operation class from the control decoder
    // 0 add, 1 compare, 2 use funct3/funct7
    typedef logic [1:0] alu_op_t;

    // ALU function picked inside execute
    typedef logic [3:0] alu_sel_t;

endpackage

// File: source/rv_decode.sv
// rv_decode splits an instruction into fields, immediate and control levels
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_decode (
    input  rv_core_pkg::word_t     instr,
    output rv_core_pkg::reg_addr_t rs1,
    output rv_core_pkg::reg_addr_t rs2,
    output rv_core_pkg::reg_addr_t rd,
    output logic [2:0]             funct3,
    output logic                   funct7_bit5,
    output rv_core_pkg::word_t     imm,
    output logic                   branch,
    output logic                   mem_read,
    output logic                   mem_to_reg,
    output logic                   mem_write,
    output logic                   alu_src,
    output logic                   reg_write_en,
    output rv_core_pkg::alu_op_t   alu_op
);

    import rv_core_pkg::*;

    opcode_t opcode;

    assign opcode      = instr[6:0];
    assign rd          = instr[11:7];
    assign funct3      = instr[14:12];
    assign rs1         = instr[19:15];
    assign rs2         = instr[24:20];
    assign funct7_bit5 = instr[30];

    // immediate format follows the opcode
    always_comb begin
        case (opcode)
            `RV_OP_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            `RV_OP_BRANCH: begin
                // byte offset, bit 0 always zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            default: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
        endcase
    end

    rv_control u_control (
        .opcode       (opcode),
        .branch       (branch),
        .mem_read     (mem_read),
        .mem_to_reg   (mem_to_reg),
        .mem_write    (mem_write),
        .alu_src      (alu_src),
        .reg_write_en (reg_write_en),
        .alu_op       (alu_op)
    );

endmodule

// File: source/rv_execute.sv
// rv_execute picks the ALU function, computes the result and resolves branches
`timescale 1ns/1ps

module rv_execute (
    input  rv_core_pkg::word_t   rs1_data,
    input  rv_core_pkg::word_t   rs2_data,
    input  rv_core_pkg::word_t   imm,
    input  rv_core_pkg::alu_op_t alu_op,
    input  logic [2:0]           funct3,
    input  logic                 funct7_bit5,
    input  logic                 alu_src,
    input  logic                 branch,
    output rv_core_pkg::word_t   alu_result,
    output logic                 branch_taken
);

    import rv_core_pkg::*;

    localparam alu_sel_t sel_add = 4'd0;
    localparam alu_sel_t sel_sub = 4'd1;
    localparam alu_sel_t sel_and = 4'd2;
    localparam alu_sel_t sel_or  = 4'd3;
    localparam alu_sel_t sel_xor = 4'd4;
    localparam alu_sel_t sel_slt = 4'd5;
    localparam alu_sel_t sel_sll = 4'd6;
    localparam alu_sel_t sel_srl = 4'd7;

    word_t    op_b;
    alu_sel_t alu_sel;
    logic     zero;

    assign op_b = alu_src ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            2'd1: alu_sel = sel_sub;
            2'd2: begin
                case (funct3)
                    // sub only for R-type, imm bit 10 is just data for addi
                    3'b000:  alu_sel = (funct7_bit5 && !alu_src) ? sel_sub : sel_add;
                    3'b001:  alu_sel = sel_sll;
                    3'b010:  alu_sel = sel_slt;
                    3'b100:  alu_sel = sel_xor;
                    3'b101:  alu_sel = sel_srl;
                    3'b110:  alu_sel = sel_or;
                    3'b111:  alu_sel = sel_and;
                    default: alu_sel = sel_add;
                endcase
            end
            default: alu_sel = sel_add;
        endcase
    end

    always_comb begin
        case (alu_sel)
            sel_add: alu_result = rs1_data + op_b;
            sel_sub: alu_result = rs1_data - op_b;
            sel_and: alu_result = rs1_data & op_b;
            sel_or:  alu_result = rs1_data | op_b;
            sel_xor: alu_result = rs1_data ^ op_b;
            sel_slt: alu_result = word_t'($signed(rs1_data) < $signed(op_b));
            sel_sll: alu_result = rs1_data << op_b[4:0];
            sel_srl: alu_result = rs1_data >> op_b[4:0];
            default: alu_result = '0;
        endcase
    end

    // funct3[0] set means bne
    assign zero         = (alu_result == '0);
    assign branch_taken = branch && (funct3[0] ? !zero : zero);

endmodule

// File: source/rv_regfile.sv
// rv_regfile holds x1..x31 with two async read ports and one write port
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_regfile (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rv_core_pkg::reg_addr_t rs1,
    input  rv_core_pkg::reg_addr_t rs2,
    input  rv_core_pkg::reg_addr_t rd,
    input  logic                   reg_write,
    input  rv_core_pkg::word_t     rd_data,
    output rv_core_pkg::word_t     rs1_data,
    output rv_core_pkg::word_t     rs2_data
);

    import rv_core_pkg::*;

    // x0 has no storage
    word_t regs [1:`RV_NUM_REGS-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

    // reads see the old value during a same-cycle write
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: source/rv_retire.sv
// rv_retire keeps the PC, selects the next PC and the write-back value
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_retire (
    input  logic               clk,
    input  logic               arst_n,
    input  rv_core_pkg::word_t imm,
    input  logic               branch_taken,
    input  logic               mem_to_reg,
    input  rv_core_pkg::word_t alu_result,
    input  rv_core_pkg::word_t mem_rdata,
    output rv_core_pkg::word_t pc,
    output rv_core_pkg::word_t rd_data
);

    import rv_core_pkg::*;

    word_t pc_plus4;
    word_t pc_target;
    word_t pc_next;

    assign pc_plus4  = pc + word_t'(4);
    // imm is already a byte offset
    assign pc_target = pc + imm;
    assign pc_next   = branch_taken ? pc_target : pc_plus4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // loads write back memory data, everything else the ALU
    assign rd_data = mem_to_reg ? mem_rdata : alu_result;

endmodule

// File: testbench/rv_core_properties.sv
// rv_core_properties checks port-level invariants of the core
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_core_properties (
    input logic               clk,
    input logic               arst_n,
    input rv_core_pkg::word_t pc,
    input logic               mem_read,
    input logic               mem_write
);

    // one instruction is a load or a store, never both
    a_no_read_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // fetch address parked during reset
    a_reset_pc: assert property (@(posedge clk) !arst_n |-> pc == `RV_RESET_PC)
        else $error("pc left the reset address while arst_n is low");

endmodule

bind rv_core rv_core_properties u_properties (
    .clk       (clk),
    .arst_n    (arst_n),
    .pc        (pc),
    .mem_read  (mem_read),
    .mem_write (mem_write)
);

// File: testbench/rv_core_tb.sv
// rv_core_tb runs assembled test programs on the core against an ISA model
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_core_tb;

    import rv_core_pkg::*;

    localparam word_t nop = 32'h0000_0013;
    // add sub sll slt xor srl or and, lowest first
    localparam logic [23:0] r_funct3 = {3'd7, 3'd6, 3'd5, 3'd4, 3'd2, 3'd1, 3'd0, 3'd0};
    // addi andi ori xori slti, lowest first
    localparam logic [14:0] i_funct3 = {3'd2, 3'd4, 3'd6, 3'd7, 3'd0};

    logic   clk = 1'b0;
    logic   arst_n = 1'b0;
    word_t  instr = nop;
    word_t  mem_rdata;
    word_t  pc;
    word_t  mem_addr;
    word_t  mem_wdata;
    logic   mem_read;
    logic   mem_write;

    word_t  prog [64];
    word_t  init_mem [64];
    word_t  dmem [64];
    integer seed = 16000;
    int     prog_len = 0;
    int     test_start [7];
    string  test_name [6] = '{"r-type alu", "i-type alu", "load/store", "branches",
                              "unknown opcode", "x0 writes"};
    int     cycles = 0;
    int     cur_test = 0;
    int     test_errs = 0;
    int     passed = 0;
    int     failed = 0;

    // ISA model state and the expectations of the current instruction
    word_t  ref_pc;
    word_t  ref_regs [32];
    word_t  ref_mem [64];
    word_t  next_pc;
    word_t  exp_addr;
    word_t  exp_wdata;
    logic   exp_wr;
    logic   exp_rd;

    rv_core i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr     (instr),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    always #50 clk = ~clk;

    assign mem_rdata = dmem[mem_addr[7:2]];

    // data memory, reloaded while reset is low
    always @(posedge clk) begin
        if (!arst_n) begin
            dmem <= init_mem;
        end else if (mem_write) begin
            dmem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_R};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    // one of eight registers starting at base
    function automatic logic [4:0] random_reg(input logic [4:0] base);
        word_t r;
        r = $random(seed);
        return base + {2'b00, r[2:0]};
    endfunction

    function automatic logic [11:0] word_addr();
        word_t r;
        r = $random(seed);
        return {4'd0, r[5:0], 2'b00};
    endfunction

    function automatic logic [11:0] random_imm();
        word_t r;
        r = $random(seed);
        return r[11:0];
    endfunction

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input logic sub,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd4: return a ^ b;
            3'd5: return a >> b[4:0];
            3'd6: return a | b;
            3'd7: return a & b;
            default: return a + b;
        endcase
    endfunction

    // executes one instruction on the model, returns the next pc
    function automatic word_t model_step(input word_t ins, output logic wr,
                                         output logic rd_en, output word_t addr,
                                         output word_t wdata);
        word_t a;
        word_t b;
        word_t imm_i;
        word_t res;
        word_t next;
        logic  wb;
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        wr    = 1'b0;
        rd_en = 1'b0;
        addr  = '0;
        wdata = b;
        res   = '0;
        wb    = 1'b0;
        next  = ref_pc + 32'd4;
        case (ins[6:0])
            `RV_OP_R: begin
                res = alu_ref(ins[14:12], ins[30], a, b);
                wb  = 1'b1;
            end
            `RV_OP_IMM: begin
                res = alu_ref(ins[14:12], 1'b0, a, imm_i);
                wb  = 1'b1;
            end
            `RV_OP_LOAD: begin
                addr  = a + imm_i;
                rd_en = 1'b1;
                res   = ref_mem[addr[7:2]];
                wb    = 1'b1;
            end
            `RV_OP_STORE: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                wr   = 1'b1;
                ref_mem[addr[7:2]] = b;
            end
            `RV_OP_BRANCH: begin
                // funct3 bit 0 turns beq into bne
                if ((a == b) ^ ins[12]) begin
                    next = ref_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                     ins[11:8], 1'b0};
                end
            end
            default: wb = 1'b0;
        endcase
        if (wb && ins[11:7] != 5'd0) begin
            ref_regs[ins[11:7]] = res;
        end
        return next;
    endfunction

    task automatic report_mismatch(input string field, input word_t got, input word_t want);
        $display("Fail %0d ns: %s is %h, expected %h", $time, field, got, want);
        test_errs++;
    endtask

    task automatic reset_model();
        ref_pc = `RV_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_mem = init_mem;
    endtask

    // memory image check, then the result line of the test
    task automatic close_test();
        for (int i = 0; i < 64; i++) begin
            if (dmem[i] !== ref_mem[i]) begin
                report_mismatch($sformatf("data word %0d", i), dmem[i], ref_mem[i]);
            end
        end
        $display("test %0d %s: %0s, %0d mismatches", cur_test + 1, test_name[cur_test],
                 (test_errs == 0) ? "pass" : "fail", test_errs);
        if (test_errs == 0) begin
            passed++;
        end else begin
            failed++;
        end
        test_errs = 0;
        cur_test++;
    endtask

    initial begin
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rd;
        logic [11:0] a;
        for (int k = 0; k < 64; k++) begin
            init_mem[k] = $random(seed);
            prog[k] = nop;
        end
        // two loaded operands through all eight R-type operations
        test_start[0] = prog_len;
        ra = random_reg(5'd1);
        rb = random_reg(5'd1);
        emit(i_type(word_addr(), 5'd0, 3'd2, ra, `RV_OP_LOAD));
        emit(i_type(word_addr(), 5'd0, 3'd2, rb, `RV_OP_LOAD));
        for (int i = 0; i < 8; i++) begin
            rd = random_reg(5'd17);
            emit(r_type((i == 1) ? 7'h20 : 7'h00, rb, ra, r_funct3[i*3 +: 3], rd));
            emit(s_type(word_addr(), rd, 5'd0));
        end
        test_start[1] = prog_len;
        for (int i = 0; i < 5; i++) begin
            rd = random_reg(5'd17);
            emit(i_type(random_imm(), ra, i_funct3[i*3 +: 3], rd, `RV_OP_IMM));
            emit(s_type(word_addr(), rd, 5'd0));
        end
        // store, load back, store again
        test_start[2] = prog_len;
        for (int i = 0; i < 3; i++) begin
            a  = word_addr();
            rd = random_reg(5'd17);
            emit(s_type(a, random_reg(5'd1), 5'd0));
            emit(i_type(a, 5'd0, 3'd2, rd, `RV_OP_LOAD));
            emit(s_type(word_addr(), rd, 5'd0));
        end
        // x1 = x2 = 5, x3 = 7
        test_start[3] = prog_len;
        emit(i_type(12'd5, 5'd0, 3'd0, 5'd1, `RV_OP_IMM));
        emit(i_type(12'd5, 5'd0, 3'd0, 5'd2, `RV_OP_IMM));
        emit(i_type(12'd7, 5'd0, 3'd0, 5'd3, `RV_OP_IMM));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'd0));
        emit(s_type(12'd0, 5'd1, 5'd0));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'd1));
        emit(s_type(12'd4, 5'd3, 5'd0));
        emit(b_type(13'd8, 5'd3, 5'd1, 3'd0));
        emit(b_type(13'd8, 5'd3, 5'd1, 3'd1));
        emit(b_type(13'd12, 5'd0, 5'd0, 3'd0));
        emit(s_type(12'd8, 5'd3, 5'd0));
        // offset -8, back to the beq x0 above
        emit(b_type(13'h1ff8, 5'd2, 5'd1, 3'd0));
        emit(s_type(12'd12, 5'd1, 5'd0));
        test_start[4] = prog_len;
        emit(i_type(12'd123, 5'd0, 3'd0, 5'd4, `RV_OP_IMM));
        emit(i_type(12'h7ff, 5'd4, 3'd0, 5'd4, 7'b1111111));
        emit(s_type(word_addr(), 5'd4, 5'd0));
        test_start[5] = prog_len;
        emit(i_type(12'd77, 5'd0, 3'd0, 5'd0, `RV_OP_IMM));
        emit(i_type(word_addr(), 5'd0, 3'd2, 5'd0, `RV_OP_LOAD));
        emit(s_type(word_addr(), 5'd0, 5'd0));
        test_start[6] = prog_len;
    end

    always @(negedge clk) begin
        if (cycles < 4) begin
            arst_n <= 1'b0;
            instr  <= nop;
        end else begin
            arst_n <= 1'b1;
            instr  <= prog[pc[7:2]];
        end
    end

    // reset, program and a margin
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > prog_len + 24) begin
            $display("timeout: the program did not reach its end within %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // compare in the middle of the low phase
    always @(negedge clk) begin
        #25;
        if (!arst_n) begin
            reset_model();
        end else begin
            while (cur_test < 5 && ref_pc >= word_t'(test_start[cur_test + 1] * 4)) begin
                close_test();
            end
            if (pc !== ref_pc) begin
                report_mismatch("pc", pc, ref_pc);
            end
            if (ref_pc == word_t'(test_start[6] * 4)) begin
                close_test();
                $display("tests passed: %0d, tests failed: %0d", passed, failed);
                if (failed == 0) begin
                    $display("Simulation passed");
                end else begin
                    $display("Simulation failed");
                end
                $finish;
            end else begin
                next_pc = model_step(prog[ref_pc[7:2]], exp_wr, exp_rd, exp_addr, exp_wdata);
                if (mem_write !== exp_wr) begin
                    report_mismatch("mem_write", word_t'(mem_write), word_t'(exp_wr));
                end
                if (mem_read !== exp_rd) begin
                    report_mismatch("mem_read", word_t'(mem_read), word_t'(exp_rd));
                end
                if ((exp_wr || exp_rd) && mem_addr !== exp_addr) begin
                    report_mismatch("mem_addr", mem_addr, exp_addr);
                end
                if (exp_wr && mem_wdata !== exp_wdata) begin
                    report_mismatch("mem_wdata", mem_wdata, exp_wdata);
                end
                ref_pc = next_pc;
            end
        end
    end

endmodule
